/* testbench/scratchpad_input.txt */
// Columns: opcode (0 lb, 1 lbu, 2 lh, 3 lhu, 4 lw, 5 sb, 6 sh, 7 sw), byte address,
// write data, expected load data, expected error flag. All values in hex.
// Word store then word load.
7 000 12345678 00000000 0
4 000 00000000 12345678 0
7 004 deadbeef 00000000 0
4 004 00000000 deadbeef 0
7 ffc cafef00d 00000000 0
4 ffc 00000000 cafef00d 0
7 100 a5a55a5a 00000000 0
4 100 00000000 a5a55a5a 0
// Narrow stores keep the other lanes.
7 010 11223344 00000000 0
5 011 000000ab 00000000 0
4 010 00000000 1122ab44 0
5 013 000000cd 00000000 0
4 010 00000000 cd22ab44 0
5 010 ffffff01 00000000 0
4 010 00000000 cd22ab01 0
6 012 0000beef 00000000 0
4 010 00000000 beefab01 0
6 010 12347788 00000000 0
4 010 00000000 beef7788 0
7 020 00000000 00000000 0
5 022 0000007e 00000000 0
6 020 0000f00f 00000000 0
4 020 00000000 007ef00f 0
5 023 00000099 00000000 0
4 020 00000000 997ef00f 0
// Sign and zero extension at every allowed offset.
7 030 f57f8001 00000000 0
0 030 00000000 00000001 0
1 030 00000000 00000001 0
0 031 00000000 ffffff80 0
1 031 00000000 00000080 0
0 032 00000000 0000007f 0
1 032 00000000 0000007f 0
0 033 00000000 fffffff5 0
1 033 00000000 000000f5 0
2 030 00000000 ffff8001 0
3 030 00000000 00008001 0
2 032 00000000 fffff57f 0
3 032 00000000 0000f57f 0
7 034 7fff00ff 00000000 0
0 034 00000000 ffffffff 0
1 034 00000000 000000ff 0
0 035 00000000 00000000 0
2 034 00000000 000000ff 0
3 034 00000000 000000ff 0
2 036 00000000 00007fff 0
3 036 00000000 00007fff 0
0 037 00000000 0000007f 0
// Misaligned requests leave memory alone.
7 040 01020304 00000000 0
6 041 0000ffff 00000000 1
6 043 0000ffff 00000000 1
7 042 ffffffff 00000000 1
7 041 ffffffff 00000000 1
7 043 ffffffff 00000000 1
4 040 00000000 01020304 0
2 041 00000000 00000000 1
3 043 00000000 00000000 1
4 042 00000000 00000000 1
4 041 00000000 00000000 1
4 043 00000000 00000000 1
0 041 00000000 00000003 0
1 043 00000000 00000001 0
2 042 00000000 00000102 0
// Back-to-back loads.
4 000 00000000 12345678 0
4 004 00000000 deadbeef 0
4 010 00000000 beef7788 0
1 012 00000000 000000ef 0
0 013 00000000 ffffffbe 0
3 012 00000000 0000beef 0
2 012 00000000 ffffbeef 0
4 ffc 00000000 cafef00d 0
4 100 00000000 a5a55a5a 0
4 102 00000000 00000000 1
4 100 00000000 a5a55a5a 0
7 100 01010101 00000000 0
4 100 00000000 01010101 0
3 ffe 00000000 0000cafe 0
0 ffd 00000000 fffffff0 0

/* flist.f */
rtl/scratchpad_pkg.sv
rtl/scratchpad_mem_1rw_sync_mask_write_byte.sv
rtl/scratchpad_store_align.sv
rtl/scratchpad_load_align.sv
rtl/scratchpad_top.sv
testbench/scratchpad_properties.sv
testbench/scratchpad_tb.sv

/* Bender.yml */
package:
  name: scratchpad

sources:
  - rtl/scratchpad_pkg.sv
  - rtl/scratchpad_mem_1rw_sync_mask_write_byte.sv
  - rtl/scratchpad_store_align.sv
  - rtl/scratchpad_load_align.sv
  - rtl/scratchpad_top.sv
  - target: test
    files:
      - testbench/scratchpad_properties.sv
      - testbench/scratchpad_tb.sv

/* testbench/scratchpad_tb.sv */
`timescale 1ns/1ps

module scratchpad_tb
  import scratchpad_pkg::*;
();

  localparam int els_c        = 1024;
  localparam int addr_width_c = $clog2(els_c) + 2;
  localparam int fields_c     = 5;
  localparam int max_vec_c    = 128;
  localparam int reset_cyc_c  = 16;
  localparam int margin_cyc_c = 20;

  logic                    clk_i = 1'b0;
  logic                    rst_n_i;
  logic                    req_v_i;
  scratchpad_op_e          op_i;
  logic [addr_width_c-1:0] addr_i;
  logic [data_width_c-1:0] wdata_i;
  logic                    rdata_v_o;
  logic [data_width_c-1:0] rdata_o;
  logic                    err_o;

  // Each vector holds opcode, address, write data, load data and error flag.
  logic [31:0] vec_mem [fields_c*max_vec_c];

  logic        exp_load_q [$];
  logic        exp_err_q [$];
  logic [31:0] exp_data_q [$];
  int          exp_idx_q [$];

  int num_vec      = 0;
  int cycle_cnt    = 0;
  int cycle_limit  = reset_cyc_c + margin_cyc_c;
  int mismatch_cnt = 0;
  int timeout_cnt  = 0;
  int file_err_cnt = 0;

  scratchpad_top #(
    .els_p(els_c)
  ) u_dut (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_v_i  (req_v_i),
    .op_i     (op_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .rdata_v_o(rdata_v_o),
    .rdata_o  (rdata_o),
    .err_o    (err_o)
  );

  bind scratchpad_top scratchpad_properties u_properties (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_v_i  (req_v_i),
    .op_i     (op_i),
    .rdata_v_i(rdata_v_o),
    .err_i    (err_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic is_load_op(input logic [2:0] op);
    return (op == op_lb) || (op == op_lbu) || (op == op_lh) || (op == op_lhu) ||
           (op == op_lw);
  endfunction

  task automatic check_value(input logic [31:0] observed, input logic [31:0] expected,
                             input string what);
    if (observed !== expected)
    begin
      $display("error at %0d ns: %s is %h, expected %h", $time, what, observed, expected);
      mismatch_cnt = mismatch_cnt + 1;
    end
  endtask

  task automatic drive_vector(input int idx);
    req_v_i <= 1'b1;
    op_i    <= scratchpad_op_e'(vec_mem[fields_c*idx][2:0]);
    addr_i  <= vec_mem[fields_c*idx+1][addr_width_c-1:0];
    wdata_i <= vec_mem[fields_c*idx+2];
  endtask

  task automatic queue_expected(input int idx);
    logic err;
    err = vec_mem[fields_c*idx+4][0];
    exp_err_q.push_back(err);
    exp_load_q.push_back(!err && is_load_op(vec_mem[fields_c*idx][2:0]));
    exp_data_q.push_back(vec_mem[fields_c*idx+3]);
    exp_idx_q.push_back(idx);
  endtask

  // Empty queue means no response is due in this cycle.
  task automatic check_response();
    logic        exp_load;
    logic        exp_err;
    logic [31:0] exp_data;
    int          idx;
    exp_load = 1'b0;
    exp_err  = 1'b0;
    exp_data = '0;
    idx      = -1;
    if (exp_idx_q.size() > 0)
    begin
      exp_load = exp_load_q.pop_front();
      exp_err  = exp_err_q.pop_front();
      exp_data = exp_data_q.pop_front();
      idx      = exp_idx_q.pop_front();
    end
    check_value(32'(rdata_v_o), 32'(exp_load), $sformatf("vector %0d rdata_v_o", idx));
    check_value(32'(err_o), 32'(exp_err), $sformatf("vector %0d err_o", idx));
    if (exp_load)
    begin
      check_value(rdata_o, exp_data, $sformatf("vector %0d rdata_o", idx));
    end
  endtask

  task automatic finish_run();
    int total;
    total = mismatch_cnt + timeout_cnt + file_err_cnt + u_dut.u_properties.fail_cnt;
    $display("Mismatches: %0d, timeouts: %0d, file errors: %0d, assertion failures: %0d",
             mismatch_cnt, timeout_cnt, file_err_cnt, u_dut.u_properties.fail_cnt);
    if (total == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  endtask

  always @(posedge clk_i)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("The run did not finish within %0d clock cycles and was stopped", cycle_limit);
      timeout_cnt = timeout_cnt + 1;
      finish_run();
    end
  end

  initial
  begin
    rst_n_i = 1'b0;
    req_v_i = 1'b0;
    op_i    = op_lw;
    addr_i  = '0;
    wdata_i = '0;

    // All ones marks the end of the vectors.
    for (int i = 0; i < fields_c*max_vec_c; i++)
    begin
      vec_mem[i] = '1;
    end
    $readmemh("testbench/scratchpad_input.txt", vec_mem);
    while ((num_vec < max_vec_c) && (vec_mem[fields_c*num_vec] !== '1))
    begin
      num_vec = num_vec + 1;
    end
    cycle_limit = num_vec + reset_cyc_c + margin_cyc_c;

    if (num_vec == 0)
    begin
      $display("No vectors could be read from testbench/scratchpad_input.txt");
      file_err_cnt = file_err_cnt + 1;
    end
    else
    begin
      repeat (reset_cyc_c) @(posedge clk_i);
      rst_n_i <= 1'b1;
      for (int i = 0; i < num_vec; i++)
      begin
        @(posedge clk_i);
        drive_vector(i);
        @(negedge clk_i);
        check_response();
        queue_expected(i);
      end
      @(posedge clk_i);
      req_v_i <= 1'b0;
      @(negedge clk_i);
      check_response();
      // One idle cycle with no response.
      @(posedge clk_i);
      @(negedge clk_i);
      check_response();
    end
    finish_run();
  end

endmodule

/* testbench/scratchpad_properties.sv */
`timescale 1ns/1ps

module scratchpad_properties
  import scratchpad_pkg::*;
(
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           req_v_i,
  input scratchpad_op_e op_i,
  input logic           rdata_v_i,
  input logic           err_i
);

  // Number of failed assertions.
  int fail_cnt = 0;

  logic load_req;

  assign load_req = req_v_i && (op_i inside {op_lb, op_lbu, op_lh, op_lhu, op_lw});

  // A load response and an error never share a cycle.
  property no_overlap_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      !(rdata_v_i && err_i);
  endproperty

  // Load data only comes back one cycle after a load request.
  property rdata_after_load_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      rdata_v_i |-> $past(load_req);
  endproperty

  property outputs_known_p;
    @(posedge clk_i) disable iff (!rst_n_i)
      !$isunknown({rdata_v_i, err_i});
  endproperty

  no_overlap_a: assert property (no_overlap_p)
  else
  begin
    $error("rdata_v_o and err_o are high in the same cycle");
    fail_cnt = fail_cnt + 1;
  end

  rdata_after_load_a: assert property (rdata_after_load_p)
  else
  begin
    $error("rdata_v_o pulse without a load request one cycle earlier");
    fail_cnt = fail_cnt + 1;
  end

  outputs_known_a: assert property (outputs_known_p)
  else
  begin
    $error("rdata_v_o or err_o is unknown after reset");
    fail_cnt = fail_cnt + 1;
  end

endmodule

/* rtl/scratchpad_top.sv */
`timescale 1ns/1ps

module scratchpad_top
  import scratchpad_pkg::*;
#(
  parameter int els_p = 1024,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_v_i,
  input  scratchpad_op_e           op_i,
  input  logic [addr_width_lp+1:0] addr_i,
  input  logic [data_width_c-1:0]  wdata_i,
  output logic                     rdata_v_o,
  output logic [data_width_c-1:0]  rdata_o,
  output logic                     err_o
);

  logic                     mem_v;
  logic                     mem_w;
  logic [addr_width_lp-1:0] mem_addr;
  logic [data_width_c-1:0]  mem_wdata;
  logic [mask_width_c-1:0]  mem_mask;
  logic [data_width_c-1:0]  mem_rdata;
  logic                     load_v;
  logic                     misaligned;

  scratchpad_store_align #(
    .els_p(els_p)
  ) u_store_align (
    .req_v_i     (req_v_i),
    .op_i        (op_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .mem_v_o     (mem_v),
    .mem_w_o     (mem_w),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_mask_o  (mem_mask),
    .load_v_o    (load_v),
    .misaligned_o(misaligned)
  );

  scratchpad_mem_1rw_sync_mask_write_byte #(
    .els_p(els_p)
  ) u_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .v_i         (mem_v),
    .w_i         (mem_w),
    .addr_i      (mem_addr),
    .data_i      (mem_wdata),
    .write_mask_i(mem_mask),
    .data_o      (mem_rdata)
  );

  scratchpad_load_align u_load_align (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .load_v_i   (load_v),
    .op_i       (op_i),
    .offset_i   (addr_i[1:0]),
    .mem_rdata_i(mem_rdata),
    .rdata_v_o  (rdata_v_o),
    .rdata_o    (rdata_o)
  );

  // Error lines up with where a load response would land.
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      err_o <= 1'b0;
    end
    else
    begin
      err_o <= misaligned;
    end
  end

endmodule

/* rtl/scratchpad_load_align.sv */
`timescale 1ns/1ps

module scratchpad_load_align
  import scratchpad_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    load_v_i,
  input  scratchpad_op_e          op_i,
  input  logic [1:0]              offset_i,
  input  logic [data_width_c-1:0] mem_rdata_i,
  output logic                    rdata_v_o,
  output logic [data_width_c-1:0] rdata_o
);

  scratchpad_op_e op_q;
  logic [1:0]     offset_q;
  logic [7:0]     byte_sel;
  logic [15:0]    half_sel;

  // Response strobe follows the accepted load by one cycle.
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rdata_v_o <= 1'b0;
    end
    else
    begin
      rdata_v_o <= load_v_i;
    end
  end

  // Remember how to cut the word that comes back.
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      op_q     <= op_lw;
      offset_q <= 2'b00;
    end
    else if (load_v_i)
    begin
      op_q     <= op_i;
      offset_q <= offset_i;
    end
  end

  assign byte_sel = mem_rdata_i[8*offset_q +: 8];
  assign half_sel = mem_rdata_i[16*offset_q[1] +: 16];

  always_comb
  begin
    case (op_q)
      op_lb:
      begin
        rdata_o = {{24{byte_sel[7]}}, byte_sel};
      end
      op_lbu:
      begin
        rdata_o = {24'b0, byte_sel};
      end
      op_lh:
      begin
        rdata_o = {{16{half_sel[15]}}, half_sel};
      end
      op_lhu:
      begin
        rdata_o = {16'b0, half_sel};
      end
      default:
      begin
        // Words pass through.
        rdata_o = mem_rdata_i;
      end
    endcase
  end

endmodule

/* rtl/scratchpad_store_align.sv */
`timescale 1ns/1ps

module scratchpad_store_align
  import scratchpad_pkg::*;
#(
  parameter int els_p = 1024,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic                     req_v_i,
  input  scratchpad_op_e           op_i,
  input  logic [addr_width_lp+1:0] addr_i,
  input  logic [data_width_c-1:0]  wdata_i,
  output logic                     mem_v_o,
  output logic                     mem_w_o,
  output logic [addr_width_lp-1:0] mem_addr_o,
  output logic [data_width_c-1:0]  mem_wdata_o,
  output logic [mask_width_c-1:0]  mem_mask_o,
  output logic                     load_v_o,
  output logic                     misaligned_o
);

  logic is_store;
  logic is_byte;
  logic is_half;
  logic is_word;
  logic bad_align;

  // Size and direction decode.
  always_comb
  begin
    is_store = 1'b0;
    is_byte  = 1'b0;
    is_half  = 1'b0;
    is_word  = 1'b0;
    case (op_i)
      op_lb, op_lbu: is_byte = 1'b1;
      op_lh, op_lhu: is_half = 1'b1;
      op_lw:         is_word = 1'b1;
      op_sb:
      begin
        is_store = 1'b1;
        is_byte  = 1'b1;
      end
      op_sh:
      begin
        is_store = 1'b1;
        is_half  = 1'b1;
      end
      default:
      begin
        is_store = 1'b1;
        is_word  = 1'b1;
      end
    endcase
  end

  assign bad_align = (is_half && addr_i[0]) || (is_word && (addr_i[1:0] != 2'b00));

  assign misaligned_o = req_v_i && bad_align;
  assign mem_v_o      = req_v_i && !bad_align;
  assign mem_w_o      = mem_v_o && is_store;
  assign load_v_o     = mem_v_o && !is_store;
  assign mem_addr_o   = addr_i[addr_width_lp+1:2];

  // Narrow data is copied to every lane and the mask picks the live ones.
  always_comb
  begin
    mem_wdata_o = wdata_i;
    mem_mask_o  = '0;
    if (is_byte)
    begin
      mem_wdata_o = {4{wdata_i[7:0]}};
      mem_mask_o  = 4'b0001 << addr_i[1:0];
    end
    else if (is_half)
    begin
      mem_wdata_o = {2{wdata_i[15:0]}};
      mem_mask_o  = 4'b0011 << {addr_i[1], 1'b0};
    end
    else
    begin
      mem_mask_o  = 4'b1111;
    end
    if (!is_store)
    begin
      mem_mask_o = '0;
    end
  end

endmodule

/* rtl/scratchpad_mem_1rw_sync_mask_write_byte.sv */
`timescale 1ns/1ps

module scratchpad_mem_1rw_sync_mask_write_byte
  import scratchpad_pkg::*;
#(
  parameter int els_p = 1024,
  localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     v_i,
  input  logic                     w_i,
  input  logic [addr_width_lp-1:0] addr_i,
  input  logic [data_width_c-1:0]  data_i,
  input  logic [mask_width_c-1:0]  write_mask_i,
  output logic [data_width_c-1:0]  data_o
);

  logic [data_width_c-1:0] mem_r [els_p];

  // Only the enabled byte lanes are written.
  always_ff @(posedge clk_i)
  begin
    if (v_i && w_i)
    begin
      for (int i = 0; i < mask_width_c; i++)
      begin
        if (write_mask_i[i])
        begin
          mem_r[addr_i][8*i +: 8] <= data_i[8*i +: 8];
        end
      end
    end
  end

  // Output register keeps the last read word.
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      data_o <= '0;
    end
    else if (v_i && !w_i)
    begin
      data_o <= mem_r[addr_i];
    end
  end

endmodule

/* rtl/scratchpad_pkg.sv */
package scratchpad_pkg;

  // Word width of the load/store port.
  localparam int data_width_c = 32;

  // Byte lanes per word.
  localparam int mask_width_c = data_width_c / 8;

  // Request opcodes.
  // Loads sit below the stores in the encoding.
  typedef enum logic [2:0] {
    op_lb  = 3'd0,
    op_lbu = 3'd1,
    op_lh  = 3'd2,
    op_lhu = 3'd3,
    op_lw  = 3'd4,
    op_sb  = 3'd5,
    op_sh  = 3'd6,
    op_sw  = 3'd7
  } scratchpad_op_e;

endpackage
